// File: rtl/fetch_pkg.sv
// shared definitions for the instruction fetch memory system
// bus widths, memory command and access size encodings
// fill controller state encoding

package fetch_pkg;

	//////////////////////////////
	// widths
	//////////////////////////////

	// byte address on the memory and fetch paths
	localparam int addr_w = 16;
	// one memory transfer, also one cache line
	localparam int line_w = 64;
	// one instruction word
	localparam int inst_w = 32;
	// response and return tag, zero means none or rejected
	localparam int mem_tag_w = 4;

	//////////////////////////////
	// encodings
	//////////////////////////////

	// memory command, BUS_NONE means no request offered
	typedef enum logic [1:0] {
		BUS_NONE  = 2'h0,
		BUS_LOAD  = 2'h1,
		BUS_STORE = 2'h2
	} bus_cmd_t;

	// access size of a memory request
	typedef enum logic [1:0] {
		SIZE_BYTE   = 2'h0,
		SIZE_HALF   = 2'h1,
		SIZE_WORD   = 2'h2,
		SIZE_DOUBLE = 2'h3
	} mem_size_t;

	// icache fill FSM
	typedef enum logic [0:0] {
		FILL_IDLE = 1'b0,
		FILL_WAIT = 1'b1
	} fill_state_t;

endpackage

// File: rtl/fetch_unit.sv
// fetch unit
// program counter with redirect, stall and advance
// instruction word select from the cached line

`timescale 1ns/1ps

module fetch_unit (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           stall,
	input  logic                           redirect,
	input  logic [fetch_pkg::addr_w-1:0]   redirect_pc,
	input  logic [fetch_pkg::line_w-1:0]   line_data,
	input  logic                           hit,
	output logic [fetch_pkg::addr_w-1:0]   fetch_addr,
	output logic                           fetch_valid,
	output logic [fetch_pkg::addr_w-1:0]   fetch_pc,
	output logic [fetch_pkg::inst_w-1:0]   fetch_inst
);
	import fetch_pkg::*;

	logic [addr_w-1:0] next_pc;

	// the cache is looked up with the current pc
	assign fetch_addr = fetch_pc;

	// a redirect kills the fetch in its own cycle
	assign fetch_valid = hit && !stall && !redirect;

	// bit 2 picks the upper or lower word of the line
	assign fetch_inst = fetch_pc[2] ? line_data[2*inst_w-1:inst_w] : line_data[inst_w-1:0];

	// redirect wins over stall, advance only on a delivered fetch
	always_comb begin
		next_pc = fetch_pc;
		if (redirect) begin
			next_pc = redirect_pc;
		end else if (fetch_valid) begin
			next_pc = fetch_pc + addr_w'(4);
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			fetch_pc <= '0;
		end else begin
			fetch_pc <= next_pc;
		end
	end

endmodule

// File: rtl/icache_mem.sv
// direct-mapped instruction cache array
// valid bits, tags and line data per entry
// combinational hit lookup, single fill write port

`timescale 1ns/1ps

module icache_mem #(
	parameter  int num_lines = 32,
	localparam int index_w   = $clog2(num_lines),
	localparam int tag_w     = fetch_pkg::addr_w - index_w - 3
) (
	input  logic                           clock,
	input  logic                           reset,
	input  logic [fetch_pkg::addr_w-1:0]   fetch_addr,
	input  logic                           fill_en,
	input  logic [index_w-1:0]             fill_index,
	input  logic [tag_w-1:0]               fill_tag,
	input  logic [fetch_pkg::line_w-1:0]   mem_line,
	output logic [fetch_pkg::line_w-1:0]   line_data,
	output logic                           hit
);
	import fetch_pkg::*;

	logic              valid [num_lines];
	logic [tag_w-1:0]  tags  [num_lines];
	logic [line_w-1:0] lines [num_lines];

	logic [index_w-1:0] rd_index;
	logic [tag_w-1:0]   rd_tag;

	// split the fetch address, low 3 bits are the byte offset
	assign rd_index = fetch_addr[index_w+2:3];
	assign rd_tag   = fetch_addr[addr_w-1:index_w+3];

	// lookup
	assign line_data = lines[rd_index];
	assign hit       = valid[rd_index] && (tags[rd_index] == rd_tag);

	// valid bits
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < num_lines; i++) begin
				valid[i] <= 1'b0;
			end
		end else if (fill_en) begin
			valid[fill_index] <= 1'b1;
		end
	end

	// tag and data written together with the valid bit
	always_ff @(posedge clock) begin
		if (fill_en) begin
			tags[fill_index]  <= fill_tag;
			lines[fill_index] <= mem_line;
		end
	end

endmodule

// File: rtl/icache_ctrl.sv
// icache fill controller
// issues a line load on a miss and waits for its tag
// drives the fill write into the cache array

`timescale 1ns/1ps

module icache_ctrl #(
	parameter  int num_lines = 32,
	localparam int index_w   = $clog2(num_lines),
	localparam int tag_w     = fetch_pkg::addr_w - index_w - 3
) (
	input  logic                             clock,
	input  logic                             reset,
	input  logic [fetch_pkg::addr_w-1:0]     fetch_addr,
	input  logic                             hit,
	input  logic [fetch_pkg::mem_tag_w-1:0]  imem_response,
	input  logic [fetch_pkg::mem_tag_w-1:0]  imem_tag,
	output fetch_pkg::bus_cmd_t              imem_command,
	output logic [fetch_pkg::addr_w-1:0]     imem_addr,
	output logic                             fill_en,
	output logic [index_w-1:0]               fill_index,
	output logic [tag_w-1:0]                 fill_tag
);
	import fetch_pkg::*;

	fill_state_t state;

	// transaction in flight
	logic [mem_tag_w-1:0] wait_tag;
	logic [index_w-1:0]   miss_index;
	logic [tag_w-1:0]     miss_tag;

	logic [index_w-1:0] addr_index;
	logic [tag_w-1:0]   addr_tag;
	logic               miss_req;
	logic               req_taken;

	assign addr_index = fetch_addr[index_w+2:3];
	assign addr_tag   = fetch_addr[addr_w-1:index_w+3];

	//////////////////////////////
	// request side
	//////////////////////////////

	// only one fill at a time, nothing is offered while waiting
	assign miss_req  = (state == FILL_IDLE) && !hit;
	// nonzero response means the memory took it
	assign req_taken = miss_req && (imem_response != '0);

	// line aligned load, repeated every cycle until accepted
	assign imem_command = miss_req ? BUS_LOAD : BUS_NONE;
	assign imem_addr    = {addr_tag, addr_index, 3'b000};

	//////////////////////////////
	// return side
	//////////////////////////////

	// write the line in the cycle its tag comes back
	assign fill_en    = (state == FILL_WAIT) && (imem_tag == wait_tag);
	assign fill_index = miss_index;
	assign fill_tag   = miss_tag;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= FILL_IDLE;
		end else begin
			case (state)
				FILL_IDLE: begin
					if (req_taken) begin
						state <= FILL_WAIT;
					end
				end
				FILL_WAIT: begin
					if (fill_en) begin
						state <= FILL_IDLE;
					end
				end
				default: begin
					state <= FILL_IDLE;
				end
			endcase
		end
	end

	// miss address is held, a redirect mid fill still finishes the old line
	always_ff @(posedge clock) begin
		if (req_taken) begin
			wait_tag   <= imem_response;
			miss_index <= addr_index;
			miss_tag   <= addr_tag;
		end
	end

endmodule

// File: rtl/mem_arbiter.sv
// memory port arbiter
// data side has priority over instruction side
// owner table steers returned tags back to the requester

`timescale 1ns/1ps

module mem_arbiter (
	input  logic                             clock,
	input  logic                             reset,
	input  fetch_pkg::bus_cmd_t              imem_command,
	input  logic [fetch_pkg::addr_w-1:0]     imem_addr,
	output logic [fetch_pkg::mem_tag_w-1:0]  imem_response,
	output logic [fetch_pkg::mem_tag_w-1:0]  imem_tag,
	input  fetch_pkg::bus_cmd_t              dmem_command,
	input  logic [fetch_pkg::addr_w-1:0]     dmem_addr,
	input  fetch_pkg::mem_size_t             dmem_size,
	input  logic [fetch_pkg::line_w-1:0]     dmem_data,
	output logic [fetch_pkg::mem_tag_w-1:0]  dmem_response,
	output logic [fetch_pkg::mem_tag_w-1:0]  dmem_tag,
	output logic [fetch_pkg::line_w-1:0]     dmem_line,
	output fetch_pkg::bus_cmd_t              proc2mem_command,
	output logic [fetch_pkg::addr_w-1:0]     proc2mem_addr,
	output logic [fetch_pkg::line_w-1:0]     proc2mem_data,
	output fetch_pkg::mem_size_t             proc2mem_size,
	input  logic [fetch_pkg::mem_tag_w-1:0]  mem2proc_response,
	input  logic [fetch_pkg::mem_tag_w-1:0]  mem2proc_tag,
	input  logic [fetch_pkg::line_w-1:0]     mem2proc_data,
	output logic [fetch_pkg::line_w-1:0]     mem_line
);
	import fetch_pkg::*;

	// one bit per tag, set means the data side owns it
	logic [2**mem_tag_w-1:0] owner_d;
	logic                    d_sel;
	logic                    ret_d;

	// data side wins whenever it offers a command
	assign d_sel = (dmem_command != BUS_NONE);

	// request mux, instruction side always loads a full line
	assign proc2mem_command = d_sel ? dmem_command : imem_command;
	assign proc2mem_addr    = d_sel ? dmem_addr : imem_addr;
	assign proc2mem_data    = d_sel ? dmem_data : '0;
	assign proc2mem_size    = d_sel ? dmem_size : SIZE_DOUBLE;

	// loser sees a rejection
	assign dmem_response = d_sel ? mem2proc_response : '0;
	assign imem_response = d_sel ? '0 : mem2proc_response;

	// record who got each accepted tag
	always_ff @(posedge clock) begin
		if (reset) begin
			owner_d <= '0;
		end else if ((proc2mem_command != BUS_NONE) && (mem2proc_response != '0)) begin
			owner_d[mem2proc_response] <= d_sel;
		end
	end

	// returns go only to the owner
	assign ret_d    = owner_d[mem2proc_tag];
	assign dmem_tag = ret_d ? mem2proc_tag : '0;
	assign imem_tag = ret_d ? '0 : mem2proc_tag;

	// data is broadcast, the tag qualifies it
	assign mem_line  = mem2proc_data;
	assign dmem_line = mem2proc_data;

endmodule

// File: rtl/fetch_top.sv
// instruction fetch memory system top level
// fetch unit, icache array and fill controller
// arbiter sharing the memory port with the data side

`timescale 1ns/1ps

module fetch_top #(
	parameter int num_lines = 32
) (
	input  logic                             clock,
	input  logic                             reset,
	input  logic                             stall,
	input  logic                             redirect,
	input  logic [fetch_pkg::addr_w-1:0]     redirect_pc,
	output logic                             fetch_valid,
	output logic [fetch_pkg::addr_w-1:0]     fetch_pc,
	output logic [fetch_pkg::inst_w-1:0]     fetch_inst,
	input  fetch_pkg::bus_cmd_t              dmem_command,
	input  logic [fetch_pkg::addr_w-1:0]     dmem_addr,
	input  fetch_pkg::mem_size_t             dmem_size,
	input  logic [fetch_pkg::line_w-1:0]     dmem_data,
	output logic [fetch_pkg::mem_tag_w-1:0]  dmem_response,
	output logic [fetch_pkg::mem_tag_w-1:0]  dmem_tag,
	output logic [fetch_pkg::line_w-1:0]     dmem_line,
	output fetch_pkg::bus_cmd_t              proc2mem_command,
	output logic [fetch_pkg::addr_w-1:0]     proc2mem_addr,
	output logic [fetch_pkg::line_w-1:0]     proc2mem_data,
	output fetch_pkg::mem_size_t             proc2mem_size,
	input  logic [fetch_pkg::mem_tag_w-1:0]  mem2proc_response,
	input  logic [fetch_pkg::mem_tag_w-1:0]  mem2proc_tag,
	input  logic [fetch_pkg::line_w-1:0]     mem2proc_data
);
	import fetch_pkg::*;

	localparam int index_w = $clog2(num_lines);
	localparam int tag_w   = addr_w - index_w - 3;

	// fetch unit to cache
	logic [addr_w-1:0] fetch_addr;
	logic [line_w-1:0] line_data;
	logic              hit;

	// controller to cache
	logic               fill_en;
	logic [index_w-1:0] fill_index;
	logic [tag_w-1:0]   fill_tag;

	// controller to arbiter
	bus_cmd_t             imem_command;
	logic [addr_w-1:0]    imem_addr;
	logic [mem_tag_w-1:0] imem_response;
	logic [mem_tag_w-1:0] imem_tag;
	logic [line_w-1:0]    mem_line;

	//////////////////////////////
	// fetch and cache
	//////////////////////////////

	fetch_unit u_fetch_unit (
		.clock, .reset, .stall, .redirect, .redirect_pc,
		.line_data, .hit, .fetch_addr, .fetch_valid, .fetch_pc, .fetch_inst
	);

	icache_mem #(.num_lines(num_lines)) u_icache_mem (
		.clock, .reset, .fetch_addr, .fill_en, .fill_index, .fill_tag,
		.mem_line, .line_data, .hit
	);

	icache_ctrl #(.num_lines(num_lines)) u_icache_ctrl (
		.clock, .reset, .fetch_addr, .hit, .imem_response, .imem_tag,
		.imem_command, .imem_addr, .fill_en, .fill_index, .fill_tag
	);

	//////////////////////////////
	// memory port
	//////////////////////////////

	mem_arbiter u_mem_arbiter (
		.clock, .reset,
		.imem_command, .imem_addr, .imem_response, .imem_tag,
		.dmem_command, .dmem_addr, .dmem_size, .dmem_data,
		.dmem_response, .dmem_tag, .dmem_line,
		.proc2mem_command, .proc2mem_addr, .proc2mem_data, .proc2mem_size,
		.mem2proc_response, .mem2proc_tag, .mem2proc_data,
		.mem_line
	);

endmodule

// File: verification/mem_model.sv
// tagged memory model for the fetch testbench
// same cycle accept with tags 1 to 15 in rotation
// return latency of 1 to 4 cycles from a Galois LFSR
// line data derived from the request address

`timescale 1ns/1ps

module mem_model (
	input  logic                             clock,
	input  logic                             reset,
	input  fetch_pkg::bus_cmd_t              proc2mem_command,
	input  logic [fetch_pkg::addr_w-1:0]     proc2mem_addr,
	output logic [fetch_pkg::mem_tag_w-1:0]  mem2proc_response,
	output logic [fetch_pkg::mem_tag_w-1:0]  mem2proc_tag,
	output logic [fetch_pkg::line_w-1:0]     mem2proc_data
);
	import fetch_pkg::*;

	localparam logic [31:0] pattern_key = 32'h5a5a0000;

	// per tag bookkeeping, entry 0 unused
	logic                 pending   [16];
	logic [1:0]           remaining [16];
	logic [addr_w-1:0]    req_addr  [16];
	logic [mem_tag_w-1:0] next_tag;
	logic [mem_tag_w-1:0] ret_tag;
	logic [31:0]          lfsr;
	logic [31:0]          lfsr_mid;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// two steps per accept, one latency bit each
	assign lfsr_mid = lfsr_step(lfsr);

	// accept unless the next tag in rotation is still out
	assign mem2proc_response =
		(!reset && (proc2mem_command != BUS_NONE) && !pending[next_tag]) ? next_tag : '0;

	// lowest tag whose latency has run out goes back first
	always_comb begin
		ret_tag = '0;
		for (int t = 15; t >= 1; t--) begin
			if (pending[t] && (remaining[t] == 2'd0)) begin
				ret_tag = mem_tag_w'(t);
			end
		end
	end

	assign mem2proc_tag  = ret_tag;
	// lower word at A, upper word at A+4
	assign mem2proc_data = (ret_tag == '0) ? '0 :
		{(({16'h0000, req_addr[ret_tag]} + 32'd4) ^ pattern_key),
		 ({16'h0000, req_addr[ret_tag]} ^ pattern_key)};

	always_ff @(posedge clock) begin
		if (reset) begin
			next_tag <= 4'd1;
			lfsr     <= 32'h092133d0;
			for (int t = 0; t < 16; t++) begin
				pending[t]   <= 1'b0;
				remaining[t] <= 2'd0;
			end
		end else begin
			for (int t = 1; t < 16; t++) begin
				if (pending[t] && (remaining[t] != 2'd0)) begin
					remaining[t] <= remaining[t] - 2'd1;
				end
			end
			if (ret_tag != '0) begin
				pending[ret_tag] <= 1'b0;
			end
			// stores are answered like loads, their data is dropped
			if (mem2proc_response != '0) begin
				pending[next_tag]   <= 1'b1;
				remaining[next_tag] <= {lfsr_mid[0], lfsr[0]};
				req_addr[next_tag]  <= proc2mem_addr;
				lfsr                <= lfsr_step(lfsr_mid);
				next_tag            <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
			end
		end
	end

endmodule

// File: verification/fetch_tb.sv
// testbench for the instruction fetch memory system
// clock, reset, posedge monitor and cycle timeout
// directed tests with typed compare tasks and a closing report

`timescale 1ns/1ps

module fetch_tb;
	import fetch_pkg::*;

	localparam int          timeout_cycles = 2000;
	localparam logic [31:0] pattern_key    = 32'h5a5a0000;
	// data side write data, never expected on an instruction request
	localparam logic [line_w-1:0] d_payload = 64'h0123_4567_89ab_cdef;

	logic                 clock;
	logic                 reset;
	logic                 stall;
	logic                 redirect;
	logic [addr_w-1:0]    redirect_pc;
	logic                 fetch_valid;
	logic [addr_w-1:0]    fetch_pc;
	logic [inst_w-1:0]    fetch_inst;
	bus_cmd_t             dmem_command;
	logic [addr_w-1:0]    dmem_addr;
	mem_size_t            dmem_size;
	logic [line_w-1:0]    dmem_data;
	logic [mem_tag_w-1:0] dmem_response;
	logic [mem_tag_w-1:0] dmem_tag;
	logic [line_w-1:0]    dmem_line;
	bus_cmd_t             proc2mem_command;
	logic [addr_w-1:0]    proc2mem_addr;
	logic [line_w-1:0]    proc2mem_data;
	mem_size_t            proc2mem_size;
	logic [mem_tag_w-1:0] mem2proc_response;
	logic [mem_tag_w-1:0] mem2proc_tag;
	logic [line_w-1:0]    mem2proc_data;

	// written by the monitor only
	int                   cycle_count    = 0;
	int                   icmd_count     = 0;
	int                   d_acc_count    = 0;
	int                   d_ret_count    = 0;
	logic                 first_cmd_seen = 1'b0;
	bus_cmd_t             first_cmd;
	logic [addr_w-1:0]    first_addr;
	mem_size_t            first_size;
	logic [line_w-1:0]    first_data;
	logic [mem_tag_w-1:0] d_acc_tag;
	mem_size_t            d_acc_size;
	logic [line_w-1:0]    d_acc_data;
	logic [mem_tag_w-1:0] d_ret_tag;
	logic [line_w-1:0]    d_ret_line;
	logic [addr_w-1:0]    pc_seen   [$];
	logic [inst_w-1:0]    inst_seen [$];

	// written by the test sequence only
	int mismatch_count = 0;
	int other_count    = 0;

	fetch_top #(.num_lines(32)) u_fetch_top (
		.clock, .reset, .stall, .redirect, .redirect_pc,
		.fetch_valid, .fetch_pc, .fetch_inst,
		.dmem_command, .dmem_addr, .dmem_size, .dmem_data,
		.dmem_response, .dmem_tag, .dmem_line,
		.proc2mem_command, .proc2mem_addr, .proc2mem_data, .proc2mem_size,
		.mem2proc_response, .mem2proc_tag, .mem2proc_data
	);

	mem_model u_mem_model (
		.clock, .reset, .proc2mem_command, .proc2mem_addr,
		.mem2proc_response, .mem2proc_tag, .mem2proc_data
	);

	always #4 clock = ~clock;

	//////////////////////////////
	// monitor
	//////////////////////////////

	// sampled at posedge, before any register updates
	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (!reset) begin
			if (fetch_valid) begin
				pc_seen.push_back(fetch_pc);
				inst_seen.push_back(fetch_inst);
			end
			if ((proc2mem_command != BUS_NONE) && !first_cmd_seen) begin
				first_cmd_seen = 1'b1;
				first_cmd      = proc2mem_command;
				first_addr     = proc2mem_addr;
				first_size     = proc2mem_size;
				first_data     = proc2mem_data;
			end
			// data side idle means the command on the port is the icache's
			if ((proc2mem_command != BUS_NONE) && (dmem_command == BUS_NONE)) begin
				icmd_count = icmd_count + 1;
			end
			if ((dmem_command != BUS_NONE) && (dmem_response != '0)) begin
				d_acc_count = d_acc_count + 1;
				d_acc_tag   = dmem_response;
				d_acc_size  = proc2mem_size;
				d_acc_data  = proc2mem_data;
			end
			if (dmem_tag != '0) begin
				d_ret_count = d_ret_count + 1;
				d_ret_tag   = dmem_tag;
				d_ret_line  = dmem_line;
			end
		end
	end

	initial begin
		wait (cycle_count >= timeout_cycles);
		$display("timeout after %0d cycles with tests still running", timeout_cycles);
		$display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
		$display("Test failed");
		$finish;
	end

	//////////////////////////////
	// compare tasks
	//////////////////////////////

	task automatic check_addr(input string name, input logic [addr_w-1:0] got,
			input logic [addr_w-1:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
			mismatch_count++;
		end
	endtask

	task automatic check_inst(input string name, input logic [inst_w-1:0] got,
			input logic [inst_w-1:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
			mismatch_count++;
		end
	endtask

	task automatic check_line(input string name, input logic [line_w-1:0] got,
			input logic [line_w-1:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
			mismatch_count++;
		end
	endtask

	task automatic check_tag(input string name, input logic [mem_tag_w-1:0] got,
			input logic [mem_tag_w-1:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
			mismatch_count++;
		end
	endtask

	task automatic check_cmd(input string name, input bus_cmd_t got, input bus_cmd_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
			mismatch_count++;
		end
	endtask

	task automatic check_size(input string name, input mem_size_t got, input mem_size_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
			mismatch_count++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
			mismatch_count++;
		end
	endtask

	//////////////////////////////
	// helpers
	//////////////////////////////

	// memory image word at a byte address
	function automatic logic [inst_w-1:0] pattern_word(input logic [addr_w-1:0] addr);
		return {16'h0000, addr} ^ pattern_key;
	endfunction

	task automatic wait_fetches(input int n);
		while (pc_seen.size() < n) @(negedge clock);
	endtask

	// n fetches from index base, expected in order from start
	task automatic check_fetches(input int base, input int n, input logic [addr_w-1:0] start);
		logic [addr_w-1:0] exp;
		wait_fetches(base + n);
		for (int i = 0; i < n; i++) begin
			exp = start + addr_w'(4 * i);
			check_addr("fetch_pc", pc_seen[base + i], exp);
			check_inst("fetch_inst", inst_seen[base + i], pattern_word(exp));
		end
	endtask

	// one cycle pulse, base marks where the new stream starts
	task automatic redirect_to(input logic [addr_w-1:0] pc, output int base);
		redirect    = 1'b1;
		redirect_pc = pc;
		@(negedge clock);
		redirect = 1'b0;
		base     = pc_seen.size();
	endtask

	//////////////////////////////
	// tests
	//////////////////////////////

	// data side idles with a byte size and nonzero data
	task automatic test_first_command();
		while (!first_cmd_seen) @(negedge clock);
		check_cmd("proc2mem_command", first_cmd, BUS_LOAD);
		check_addr("proc2mem_addr", first_addr, '0);
		check_size("proc2mem_size", first_size, SIZE_DOUBLE);
		check_line("proc2mem_data", first_data, '0);
	endtask

	task automatic test_sequential();
		check_fetches(0, 16, 16'h0000);
	endtask

	// lines 0 to 7 are filled by now
	task automatic test_refetch_filled();
		int base;
		int cmds;
		redirect_to(16'h0000, base);
		cmds = icmd_count;
		check_fetches(base, 8, 16'h0000);
		if (icmd_count != cmds) begin
			$display("icache issued %0d commands for lines already filled", icmd_count - cmds);
			other_count++;
		end
	endtask

	task automatic test_redirect_stall();
		int                base;
		int                seen;
		logic [addr_w-1:0] held;
		redirect_to(16'h0100, base);
		wait_fetches(base + 2);
		stall = 1'b1;
		held  = fetch_pc;
		seen  = pc_seen.size();
		repeat (6) begin
			@(negedge clock);
			check_bit("fetch_valid", fetch_valid, 1'b0);
			check_addr("fetch_pc", fetch_pc, held);
		end
		if (pc_seen.size() != seen) begin
			$display("a fetch was delivered while stall was held");
			other_count++;
		end
		stall = 1'b0;
		check_fetches(base, 6, 16'h0100);
	endtask

	// word size and payload must pass through to the memory port
	task automatic test_data_request();
		int base;
		int acc;
		int ret;
		redirect_to(16'h0200, base);
		acc          = d_acc_count;
		ret          = d_ret_count;
		dmem_command = BUS_LOAD;
		dmem_addr    = 16'h0800;
		dmem_size    = SIZE_WORD;
		dmem_data    = d_payload;
		while (d_acc_count == acc) @(negedge clock);
		dmem_command = BUS_NONE;
		check_size("proc2mem_size", d_acc_size, SIZE_WORD);
		check_line("proc2mem_data", d_acc_data, d_payload);
		while (d_ret_count == ret) @(negedge clock);
		check_tag("dmem_tag", d_ret_tag, d_acc_tag);
		check_inst("dmem_line[31:0]", d_ret_line[31:0], pattern_word(16'h0800));
		check_inst("dmem_line[63:32]", d_ret_line[63:32], pattern_word(16'h0804));
		check_fetches(base, 8, 16'h0200);
	endtask

	// icache miss at 0x400 sees rejections while the data side holds the port
	task automatic test_held_data();
		int base;
		redirect_to(16'h0400, base);
		dmem_command = BUS_LOAD;
		dmem_addr    = 16'h0a00;
		dmem_size    = SIZE_DOUBLE;
		repeat (8) @(negedge clock);
		dmem_command = BUS_NONE;
		if (pc_seen.size() != base) begin
			$display("a fetch was delivered while its line load was being rejected");
			other_count++;
		end
		check_fetches(base, 12, 16'h0400);
	endtask

	initial begin
		clock        = 1'b0;
		reset        = 1'b1;
		stall        = 1'b0;
		redirect     = 1'b0;
		redirect_pc  = '0;
		dmem_command = BUS_NONE;
		dmem_addr    = '0;
		dmem_size    = SIZE_BYTE;
		dmem_data    = d_payload;
		repeat (5) @(negedge clock);
		reset = 1'b0;

		test_first_command();
		test_sequential();
		test_refetch_filled();
		test_redirect_stall();
		test_data_request();
		test_held_data();
		repeat (4) @(negedge clock);

		$display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
		if ((mismatch_count == 0) && (other_count == 0)) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: vlog.f
rtl/fetch_pkg.sv
rtl/fetch_unit.sv
rtl/icache_mem.sv
rtl/icache_ctrl.sv
rtl/mem_arbiter.sv
rtl/fetch_top.sv
verification/mem_model.sv
verification/fetch_tb.sv

// File: Makefile
TOOL     := verilator
TOP      := fetch_tb
FILELIST := vlog.f
OBJ_DIR  := obj_dir
FLAGS    := --binary --timing --top-module $(TOP) --Mdir $(OBJ_DIR)
PASS_MSG := Test passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) -f $(FILELIST)

# exit status follows the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
